/* design/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file
`define NUM_AREGS 32
`define AREG_W 5

// reorder buffer
`define ROB_DEPTH 64
`define ROB_W 6

// entries kept free so a full pair always fits
`define ROB_HEADROOM 4

`endif

/* design/rename_pkg.sv */
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    // one alias table entry
    // check flips per rename so a reused robid is still told apart
    typedef struct packed {
        logic              check;
        logic [`ROB_W-1:0] robid;
    } rat_entry_t;

    // tag view of a source operand
    typedef struct packed {
        logic [31-`ROB_W-1:0] pad;
        logic                 check;
        logic [`ROB_W-1:0]    robid;
    } src_tag_t;

    // source operand word
    // src_ready set: data holds the architectural value
    // src_ready clear: tag names the producing instruction
    typedef union packed {
        logic [31:0] data;
        src_tag_t    tag;
    } src_operand_u;

endpackage

`default_nettype wire

/* design/spec_rat.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module spec_rat (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`AREG_W-1:0]     raddr_i [4],
    output rename_pkg::rat_entry_t rdata_o [4],
    input  logic [1:0]             we_i,
    input  logic [`AREG_W-1:0]     waddr_i [2],
    input  rename_pkg::rat_entry_t wdata_i [2],
    input  logic                   restore_i,
    input  rename_pkg::rat_entry_t restore_table_i [`NUM_AREGS]
);
    import rename_pkg::*;

    rat_entry_t table_q [`NUM_AREGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_AREGS; i++) begin
                table_q[i] <= '0;
            end
        end else if (restore_i) begin
            // flush: speculative state is replaced by the committed map
            for (int i = 0; i < `NUM_AREGS; i++) begin
                table_q[i] <= restore_table_i[i];
            end
        end else begin
            // later port wins on the same register
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    table_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // reads see the table as of the last edge
    for (genvar p = 0; p < 4; p++) begin : g_read
        assign rdata_o[p] = table_q[raddr_i[p]];
    end

endmodule

`default_nettype wire

/* design/commit_rat.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module commit_rat (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`AREG_W-1:0]     raddr_i [6],
    output rename_pkg::rat_entry_t rdata_o [6],
    input  logic [1:0]             we_i,
    input  logic [`AREG_W-1:0]     waddr_i [2],
    input  rename_pkg::rat_entry_t wdata_i [2],
    output rename_pkg::rat_entry_t table_o [`NUM_AREGS]
);
    import rename_pkg::*;

    rat_entry_t table_q [`NUM_AREGS];

    // retire writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_AREGS; i++) begin
                table_q[i] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    table_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // reads forward this cycle's retires
    // port 1 checked last so it wins
    always_comb begin
        for (int p = 0; p < 6; p++) begin
            rdata_o[p] = table_q[raddr_i[p]];
            for (int w = 0; w < 2; w++) begin
                if (we_i[w] && (waddr_i[w] == raddr_i[p])) begin
                    rdata_o[p] = wdata_i[w];
                end
            end
        end
    end

    // stored map, used to restore the speculative table
    assign table_o = table_q;

endmodule

`default_nettype wire

/* design/arch_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module arch_regfile (
    input  logic               clk,
    input  logic               reset_i,
    input  logic [`AREG_W-1:0] raddr_i [4],
    output logic [31:0]        rdata_o [4],
    input  logic [1:0]         we_i,
    input  logic [`AREG_W-1:0] waddr_i [2],
    input  logic [31:0]        wdata_i [2]
);

    logic [31:0] regs_q [`NUM_AREGS];
    logic [1:0]  we_eff;

    // register 0 is hardwired
    for (genvar w = 0; w < 2; w++) begin : g_we
        assign we_eff[w] = we_i[w] & (|waddr_i[w]);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_AREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_eff[w]) begin
                    regs_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // forwarded reads, port 1 has priority
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = regs_q[raddr_i[p]];
            for (int w = 0; w < 2; w++) begin
                if (we_eff[w] && (waddr_i[w] == raddr_i[p])) begin
                    rdata_o[p] = wdata_i[w];
                end
            end
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/rob_alloc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module rob_alloc (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              flush_i,
    input  logic [1:0]        issue_i,
    input  logic [1:0]        retire_i,
    output logic [`ROB_W-1:0] ptr0_o,
    output logic [`ROB_W-1:0] ptr1_o,
    output logic              space_o
);

    // highest count that still admits a new pair
    localparam logic [`ROB_W:0] SPACE_LIMIT = (`ROB_W+1)'(`ROB_DEPTH - `ROB_HEADROOM);

    // one extra bit so a full buffer is representable
    logic [`ROB_W:0]   count_q;
    logic [`ROB_W:0]   count_d;
    logic [1:0]        n_issue;
    logic [1:0]        n_retire;
    logic [`ROB_W-1:0] ptr0_d;
    logic [`ROB_W-1:0] ptr1_d;

    assign n_issue  = {1'b0, issue_i[0]} + {1'b0, issue_i[1]};
    assign n_retire = {1'b0, retire_i[0]} + {1'b0, retire_i[1]};

    assign count_d = count_q + {{(`ROB_W-1){1'b0}}, n_issue}
                             - {{(`ROB_W-1){1'b0}}, n_retire};

    // pointers wrap with the buffer depth
    assign ptr0_d = ptr0_o + {{(`ROB_W-2){1'b0}}, n_issue};
    assign ptr1_d = ptr1_o + {{(`ROB_W-2){1'b0}}, n_issue};

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            count_q <= '0;
            ptr0_o  <= '0;
            ptr1_o  <= {{(`ROB_W-1){1'b0}}, 1'b1};
            space_o <= 1'b1;
        end else begin
            count_q <= count_d;
            ptr0_o  <= ptr0_d;
            ptr1_o  <= ptr1_d;
            // judged on the count before this cycle's changes
            space_o <= (count_q <= SPACE_LIMIT);
        end
    end

endmodule

`default_nettype wire

/* design/rename_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module rename_stage (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    // decode side
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  logic [1:0]               in_slot_valid_i,
    input  logic [`AREG_W-1:0]       in_src_areg_i [2][2],
    input  logic [`AREG_W-1:0]       in_dst_areg_i [2],
    input  logic [1:0]               in_wreg_i,
    // issue side
    input  logic                     out_ready_i,
    output logic [1:0]               out_valid_o,
    output rename_pkg::src_operand_u out_src_o [2][2],
    output logic                     out_src_ready_o [2][2],
    output logic [`ROB_W-1:0]        out_dst_robid_o [2],
    output logic [1:0]               out_dst_check_o,
    output logic [`AREG_W-1:0]       out_dst_areg_o [2],
    // retire side
    input  logic [1:0]               retire_i,
    input  logic [1:0]               ret_wvalid_i,
    input  logic [`AREG_W-1:0]       ret_areg_i [2],
    input  logic [`ROB_W-1:0]        ret_robid_i [2],
    input  logic [1:0]               ret_check_i,
    input  logic [31:0]              ret_data_i [2]
);
    import rename_pkg::*;

    logic               space;
    logic               accept;
    logic [1:0]         issue;
    logic [1:0]         wr_en;
    logic [`ROB_W-1:0]  ptr0;
    logic [`ROB_W-1:0]  ptr1;
    rat_entry_t         new_entry [2];
    logic [`AREG_W-1:0] src_areg [4];
    logic [`AREG_W-1:0] cmt_raddr [6];
    rat_entry_t         spec_rd [4];
    rat_entry_t         cmt_rd [6];
    rat_entry_t         cmt_table [`NUM_AREGS];
    logic [31:0]        arf_rd [4];
    logic [1:0]         ret_we;
    rat_entry_t         ret_entry [2];
    logic               src_ready [2][2];
    src_operand_u       src_word [2][2];

    // handshake
    assign in_ready_o = space & ~flush_i & out_ready_i;
    assign accept     = in_valid_i & in_ready_o;
    assign issue      = in_slot_valid_i & {2{accept}};

    for (genvar s = 0; s < 2; s++) begin : g_slot
        assign wr_en[s]         = issue[s] & in_wreg_i[s] & (|in_dst_areg_i[s]);
        assign src_areg[2*s]    = in_src_areg_i[s][0];
        assign src_areg[2*s+1]  = in_src_areg_i[s][1];
        // ports 4 and 5 fetch the committed check of each destination
        assign cmt_raddr[4+s]   = in_dst_areg_i[s];
        assign ret_we[s]        = retire_i[s] & ret_wvalid_i[s] & (|ret_areg_i[s]);
        assign ret_entry[s]     = {ret_check_i[s], ret_robid_i[s]};
    end

    for (genvar i = 0; i < 4; i++) begin : g_src_addr
        assign cmt_raddr[i] = src_areg[i];
    end

    // new generation is the inverse of the committed one
    assign new_entry[0] = {~cmt_rd[4].check, ptr0};
    assign new_entry[1] = {~cmt_rd[5].check, ptr1};

    spec_rat u_spec_rat (
        .clk             (clk),
        .reset_i         (reset_i),
        .raddr_i         (src_areg),
        .rdata_o         (spec_rd),
        .we_i            (wr_en),
        .waddr_i         (in_dst_areg_i),
        .wdata_i         (new_entry),
        .restore_i       (flush_i),
        .restore_table_i (cmt_table)
    );

    commit_rat u_commit_rat (
        .clk     (clk),
        .reset_i (reset_i),
        .raddr_i (cmt_raddr),
        .rdata_o (cmt_rd),
        .we_i    (ret_we),
        .waddr_i (ret_areg_i),
        .wdata_i (ret_entry),
        .table_o (cmt_table)
    );

    arch_regfile u_arch_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .raddr_i (src_areg),
        .rdata_o (arf_rd),
        .we_i    (ret_we),
        .waddr_i (ret_areg_i),
        .wdata_i (ret_data_i)
    );

    rob_alloc u_rob_alloc (
        .clk      (clk),
        .reset_i  (reset_i),
        .flush_i  (flush_i),
        .issue_i  (issue),
        .retire_i (retire_i),
        .ptr0_o   (ptr0),
        .ptr1_o   (ptr1),
        .space_o  (space)
    );

    // operand selection
    always_comb begin
        rat_entry_t tag_sel;
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                tag_sel         = spec_rd[2*s+k];
                src_ready[s][k] = (in_src_areg_i[s][k] == '0) ||
                                  (spec_rd[2*s+k] == cmt_rd[2*s+k]);
                // slot 1 depends on slot 0 of the same pair
                if ((s == 1) && wr_en[0] && (in_src_areg_i[s][k] == in_dst_areg_i[0])) begin
                    tag_sel         = new_entry[0];
                    src_ready[s][k] = 1'b0;
                end
                if (src_ready[s][k]) begin
                    src_word[s][k].data = arf_rd[2*s+k];
                end else begin
                    src_word[s][k].tag.pad   = '0;
                    src_word[s][k].tag.check = tag_sel.check;
                    src_word[s][k].tag.robid = tag_sel.robid;
                end
            end
        end
    end

    // output register, valid bits
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            out_valid_o <= '0;
        end else if (out_ready_i) begin
            out_valid_o <= issue;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (out_ready_i) begin
            out_src_o          <= src_word;
            out_src_ready_o    <= src_ready;
            out_dst_robid_o[0] <= ptr0;
            out_dst_robid_o[1] <= ptr1;
            out_dst_check_o    <= {new_entry[1].check, new_entry[0].check};
            out_dst_areg_o     <= in_dst_areg_i;
        end
    end

endmodule

`default_nettype wire

/* dv/rename_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module rename_assertions (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               out_ready_i,
    input  logic               in_ready_i,
    input  logic [`AREG_W-1:0] in_src_areg_i [2][2],
    input  logic [1:0]         out_valid_i,
    input  logic [`ROB_W-1:0]  out_dst_robid_i [2],
    input  logic               out_src_ready_i [2][2]
);

    a_valid_clear: assert property (@(posedge clk)
        (reset_i || flush_i) |=> (out_valid_i == 2'b00))
        else $error("output valid set in the cycle after reset or flush");

    a_flush_stall: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |-> !in_ready_i)
        else $error("input ready high during flush");

    // a pair always takes consecutive ids
    a_pair_ids: assert property (@(posedge clk) disable iff (reset_i)
        (out_valid_i == 2'b11) |-> (out_dst_robid_i[1] == `ROB_W'(out_dst_robid_i[0] + 1)))
        else $error("slot 1 robid does not follow slot 0");

    for (genvar s = 0; s < 2; s++) begin : g_slot
        for (genvar k = 0; k < 2; k++) begin : g_src
            a_zero_ready: assert property (@(posedge clk) disable iff (reset_i)
                (out_ready_i && (in_src_areg_i[s][k] == '0)) |=> out_src_ready_i[s][k])
                else $error("register 0 source not marked ready");
        end
    end

endmodule

bind rename_stage rename_assertions u_rename_assertions (
    .clk             (clk),
    .reset_i         (reset_i),
    .flush_i         (flush_i),
    .out_ready_i     (out_ready_i),
    .in_ready_i      (in_ready_o),
    .in_src_areg_i   (in_src_areg_i),
    .out_valid_i     (out_valid_o),
    .out_dst_robid_i (out_dst_robid_o),
    .out_src_ready_i (out_src_ready_o)
);

`default_nettype wire

/* dv/rename_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rename_config.svh"

module rename_tb;
    import rename_pkg::*;

    // in-flight instruction record kept in age order
    typedef struct packed {
        logic               wr;
        logic [`AREG_W-1:0] areg;
        rat_entry_t         ent;
    } rob_rec_t;

    // reset, then the longest path through each test
    localparam int TOTAL_CYCLES = 4 + 3 + 400 + 407 + 18 + 160 + 53 + 1;
    localparam int SPACE_LIMIT  = `ROB_DEPTH - `ROB_HEADROOM;

    logic clk;
    logic reset_i;
    logic flush_i;
    logic in_valid_i;
    logic in_ready_o;
    logic out_ready_i;
    logic [1:0] in_slot_valid_i;
    logic [1:0] in_wreg_i;
    logic [1:0] out_valid_o;
    logic [1:0] out_dst_check_o;
    logic [1:0] retire_i;
    logic [1:0] ret_wvalid_i;
    logic [1:0] ret_check_i;
    logic [`AREG_W-1:0] in_src_areg_i [2][2];
    logic [`AREG_W-1:0] in_dst_areg_i [2];
    logic [`AREG_W-1:0] out_dst_areg_o [2];
    logic [`AREG_W-1:0] ret_areg_i [2];
    logic [`ROB_W-1:0]  out_dst_robid_o [2];
    logic [`ROB_W-1:0]  ret_robid_i [2];
    logic [31:0]        ret_data_i [2];
    src_operand_u       out_src_o [2][2];
    logic               out_src_ready_o [2][2];

    // reference model state
    rat_entry_t        spec_m [`NUM_AREGS];
    rat_entry_t        cmt_m [`NUM_AREGS];
    logic [31:0]       arf_m [`NUM_AREGS];
    rob_rec_t          rob_q [$];
    int                count_m;
    logic [`ROB_W-1:0] ptr_m;
    logic              space_m;
    logic [1:0]        exp_valid;
    logic [31:0]       exp_word [2][2];
    logic              exp_rdy [2][2];
    logic [`ROB_W-1:0] exp_robid [2];
    logic              exp_check [2];
    logic [`AREG_W-1:0] exp_areg [2];

    int    seed = 32'h093b_75e4;
    int    ret_on;
    int    oready_pct;
    string test_name;
    int    test_errs;
    int    total_errs;
    int    n_tests;
    int    n_passed;

    rename_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * 4 + 200);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        n_tests++;
        if (test_errs == 0) begin
            n_passed++;
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: %0d mismatches", test_name, test_errs);
        end
        total_errs += test_errs;
    endtask

    // random pair plus in-order retires from the front of the model queue
    task automatic random_inputs();
        int n;
        in_valid_i      <= ($unsigned($random(seed)) % 4) != 0;
        in_slot_valid_i <= 2'($random(seed));
        in_wreg_i       <= 2'($random(seed));
        out_ready_i     <= ($unsigned($random(seed)) % 100) < oready_pct;
        flush_i         <= 1'b0;
        for (int s = 0; s < 2; s++) begin
            in_dst_areg_i[s] <= `AREG_W'($unsigned($random(seed)) % 8);
            for (int k = 0; k < 2; k++) begin
                in_src_areg_i[s][k] <= `AREG_W'($unsigned($random(seed)) % 8);
            end
        end
        n = (ret_on != 0) ? int'($unsigned($random(seed)) % 3) : 0;
        if (n > rob_q.size()) begin
            n = rob_q.size();
        end
        for (int r = 0; r < 2; r++) begin
            retire_i[r]     <= (r < n);
            ret_wvalid_i[r] <= 1'b0;
            if (r < n) begin
                ret_wvalid_i[r] <= rob_q[r].wr;
                ret_areg_i[r]   <= rob_q[r].areg;
                ret_robid_i[r]  <= rob_q[r].ent.robid;
                ret_check_i[r]  <= rob_q[r].ent.check;
                ret_data_i[r]   <= $random(seed);
            end
        end
    endtask

    task automatic directed_inputs();
        random_inputs();
        in_valid_i      <= 1'b1;
        in_slot_valid_i <= 2'b11;
        in_wreg_i       <= 2'b00;
        out_ready_i     <= 1'b1;
        retire_i        <= 2'b00;
        ret_wvalid_i    <= 2'b00;
    endtask

    task automatic compare_outputs();
        check_val("out_valid", 32'(exp_valid), 32'(out_valid_o));
        for (int s = 0; s < 2; s++) begin
            if (exp_valid[s]) begin
                check_val("dst robid", 32'(exp_robid[s]), 32'(out_dst_robid_o[s]));
                check_val("dst check", 32'(exp_check[s]), 32'(out_dst_check_o[s]));
                check_val("dst areg", 32'(exp_areg[s]), 32'(out_dst_areg_o[s]));
                for (int k = 0; k < 2; k++) begin
                    check_val("src ready", 32'(exp_rdy[s][k]), 32'(out_src_ready_o[s][k]));
                    check_val("src word", exp_word[s][k], out_src_o[s][k]);
                end
            end
        end
    endtask

    // predict this cycle's outputs and advance the model past the next edge
    task automatic predict_and_update();
        rat_entry_t         cmt_f [`NUM_AREGS];
        logic [31:0]        arf_f [`NUM_AREGS];
        rat_entry_t         ne [2];
        rat_entry_t         tag;
        logic               rdy_m;
        logic [1:0]         iss;
        logic [1:0]         wen;
        logic [`AREG_W-1:0] a;
        int                 n_ret;
        cmt_f = cmt_m;
        arf_f = arf_m;
        n_ret = 0;
        for (int r = 0; r < 2; r++) begin
            if (retire_i[r]) begin
                n_ret++;
            end
            if (retire_i[r] && ret_wvalid_i[r] && (ret_areg_i[r] != '0)) begin
                cmt_f[ret_areg_i[r]] = {ret_check_i[r], ret_robid_i[r]};
                arf_f[ret_areg_i[r]] = ret_data_i[r];
            end
        end
        rdy_m = space_m && !flush_i && out_ready_i;
        check_val("in_ready", 32'(rdy_m), 32'(in_ready_o));
        for (int s = 0; s < 2; s++) begin
            iss[s] = in_valid_i && rdy_m && in_slot_valid_i[s];
            wen[s] = iss[s] && in_wreg_i[s] && (in_dst_areg_i[s] != '0);
            ne[s]  = {~cmt_f[in_dst_areg_i[s]].check, ptr_m + `ROB_W'(s)};
        end
        if (flush_i) begin
            exp_valid = 2'b00;
        end else if (out_ready_i) begin
            exp_valid = iss;
        end
        for (int s = 0; s < 2 && out_ready_i; s++) begin
            exp_robid[s] = ne[s].robid;
            exp_check[s] = ne[s].check;
            exp_areg[s]  = in_dst_areg_i[s];
            for (int k = 0; k < 2; k++) begin
                a   = in_src_areg_i[s][k];
                tag = spec_m[a];
                exp_rdy[s][k] = (a == '0) || (spec_m[a] == cmt_f[a]);
                if ((s == 1) && wen[0] && (a == in_dst_areg_i[0])) begin
                    tag = ne[0];
                    exp_rdy[s][k] = 1'b0;
                end
                exp_word[s][k] = exp_rdy[s][k] ? arf_f[a] : {25'b0, tag};
            end
        end
        for (int r = 0; r < n_ret; r++) begin
            void'(rob_q.pop_front());
        end
        // restore takes the stored table without this cycle's retires
        if (flush_i) begin
            spec_m = cmt_m;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (wen[s]) begin
                    spec_m[in_dst_areg_i[s]] = ne[s];
                end
            end
        end
        cmt_m = cmt_f;
        arf_m = arf_f;
        if (flush_i) begin
            count_m = 0;
            ptr_m   = '0;
            space_m = 1'b1;
            rob_q.delete();
        end else begin
            space_m = (count_m <= SPACE_LIMIT);
            count_m = count_m + int'(iss[0]) + int'(iss[1]) - n_ret;
            ptr_m   = ptr_m + `ROB_W'(iss[0]) + `ROB_W'(iss[1]);
            for (int s = 0; s < 2; s++) begin
                if (iss[s]) begin
                    rob_q.push_back({wen[s], in_dst_areg_i[s], ne[s]});
                end
            end
        end
    endtask

    task automatic finish_cycle();
        @(negedge clk);
        compare_outputs();
        predict_and_update();
    endtask

    task automatic random_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            random_inputs();
            finish_cycle();
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        directed_inputs();
        in_valid_i <= 1'b0;
        finish_cycle();
    endtask

    initial begin
        logic [`ROB_W-1:0] base;
        int saw_stall;
        int saw_resume;
        reset_i = 1'b1;
        flush_i = 1'b0;
        // a full pair is offered during reset and must not reach the output
        in_valid_i = 1'b1;
        out_ready_i = 1'b1;
        in_slot_valid_i = 2'b11;
        in_wreg_i = '0;
        retire_i = '0;
        ret_wvalid_i = '0;
        ret_check_i = '0;
        for (int s = 0; s < 2; s++) begin
            in_src_areg_i[s][0] = '0;
            in_src_areg_i[s][1] = '0;
            in_dst_areg_i[s] = '0;
            ret_areg_i[s] = '0;
            ret_robid_i[s] = '0;
            ret_data_i[s] = '0;
        end
        for (int i = 0; i < `NUM_AREGS; i++) begin
            spec_m[i] = '0;
            cmt_m[i] = '0;
            arf_m[i] = '0;
        end
        count_m = 0;
        ptr_m = '0;
        space_m = 1'b1;
        exp_valid = '0;
        oready_pct = 100;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        in_valid_i <= 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        check_val("valid after reset", 0, 32'(out_valid_o));
        idle_cycle();
        @(posedge clk);
        directed_inputs();
        finish_cycle();
        idle_cycle();
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                check_val("reset src ready", 1, 32'(out_src_ready_o[s][k]));
                check_val("reset src data", 0, out_src_o[s][k]);
            end
        end
        end_test();

        begin_test("random_rename_retire");
        ret_on = 1;
        oready_pct = 90;
        random_cycles(400);
        end_test();

        begin_test("intra_pair_dependence");
        oready_pct = 100;
        for (int i = 0; i < 200 && rob_q.size() > 0; i++) begin
            idle_cycle();
            @(posedge clk);
            random_inputs();
            in_valid_i <= 1'b0;
            finish_cycle();
        end
        idle_cycle();
        idle_cycle();
        base = ptr_m;
        @(posedge clk);
        directed_inputs();
        in_wreg_i <= 2'b01;
        in_dst_areg_i[0] <= 5;
        in_src_areg_i[1][0] <= 5;
        finish_cycle();
        idle_cycle();
        check_val("bypass ready", 0, 32'(out_src_ready_o[1][0]));
        check_val("bypass tag", 32'(base), 32'(out_src_o[1][0].tag.robid));
        base = ptr_m;
        @(posedge clk);
        directed_inputs();
        in_wreg_i <= 2'b11;
        in_dst_areg_i[0] <= 7;
        in_dst_areg_i[1] <= 7;
        finish_cycle();
        @(posedge clk);
        directed_inputs();
        in_src_areg_i[0][0] <= 7;
        finish_cycle();
        idle_cycle();
        check_val("same dst ready", 0, 32'(out_src_ready_o[0][0]));
        check_val("same dst tag", 32'(base + 1'b1), 32'(out_src_o[0][0].tag.robid));
        end_test();

        begin_test("back_pressure");
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            random_inputs();
            in_valid_i <= 1'b1;
            out_ready_i <= 1'b0;
            finish_cycle();
            check_val("in_ready while stalled", 0, 32'(in_ready_o));
        end
        random_cycles(10);
        end_test();

        begin_test("occupancy_stall");
        ret_on = 0;
        saw_stall = 0;
        saw_resume = 0;
        for (int i = 0; i < 60; i++) begin
            @(posedge clk);
            directed_inputs();
            finish_cycle();
            if (!in_ready_o) begin
                saw_stall = 1;
            end
        end
        ret_on = 1;
        for (int i = 0; i < 100 && saw_resume == 0; i++) begin
            random_cycles(1);
            if (in_ready_o) begin
                saw_resume = 1;
            end
        end
        if (saw_stall == 0 || saw_resume == 0) begin
            $display("occupancy: in_ready did not stall when full or did not come back");
            test_errs++;
        end
        end_test();

        begin_test("flush");
        oready_pct = 90;
        random_cycles(20);
        @(posedge clk);
        random_inputs();
        flush_i <= 1'b1;
        finish_cycle();
        @(posedge clk);
        directed_inputs();
        finish_cycle();
        idle_cycle();
        check_val("robid after flush", 0, 32'(out_dst_robid_o[0]));
        random_cycles(30);
        end_test();

        @(posedge clk);
        $display("summary: %0d tests, %0d passed, %0d mismatches", n_tests, n_passed, total_errs);
        if (total_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/rename_pkg.sv
design/spec_rat.sv
design/commit_rat.sv
design/arch_regfile.sv
design/rob_alloc.sv
design/rename_stage.sv
dv/rename_assertions.sv
dv/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rename stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module rename_tb -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rename_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    echo "result: fail"
    exit 1
fi

echo "result: pass"
exit 0
